//--- sim.f
design/fpr_fmt_pkg.sv
design/fpr_ctrl_pkg.sv
design/fpr_align.sv
design/fpr_round.sv
design/fpr_pack.sv
design/fpr_top.sv
verification/fpr_sva.sv
verification/fpr_tb.sv

//--- Makefile
# Verilator simulation of the fpr rounding pipeline
VERILATOR ?= verilator
TOP       ?= fpr_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then exit 1; fi
	@if ! grep -q -F '*** PASSED ***' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/fpr_tb.sv
/*
 * testbench for the fpr rounding pipeline: directed and random operations
 * checked in order against a reference model, plus stall and flush runs
 */
`timescale 1ns/1ns

module fpr_tb;
  import fpr_fmt_pkg::*;
  import fpr_ctrl_pkg::*;

  logic   clk, rst, adv_i, flush_i, valid_i;
  rmode_t rmode_i;
  logic   sign_i, inv_i, inf_i, snan_i, qnan_i, nan_sign_i;
  exp_t   exp_i;
  sig_t   sig_i;
  shamt_t shr_i, shl_i;
  word_t  result_o;
  flags_t flags_o;
  logic   valid_o;

  integer      seed;
  int          errors;
  int          checks;
  int          sva_fails;
  string       test_name;
  logic [39:0] exp_q[$];     // {flags, result} in issue order
  logic        last_adv;     // adv seen at the latest edge
  logic        prev_valid;
  word_t       prev_result;
  flags_t      prev_flags;

  fpr_top uut (
    .clk (clk), .rst (rst), .adv_i (adv_i), .flush_i (flush_i), .rmode_i (rmode_i),
    .valid_i (valid_i), .sign_i (sign_i), .exp_i (exp_i), .sig_i (sig_i),
    .shr_i (shr_i), .shl_i (shl_i), .inv_i (inv_i), .inf_i (inf_i),
    .snan_i (snan_i), .qnan_i (qnan_i), .nan_sign_i (nan_sign_i),
    .result_o (result_o), .flags_o (flags_o), .valid_o (valid_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // spec is {inv, inf, snan, qnan, nan_sign}
  function automatic logic [39:0] fpr_ref(input rmode_t rm, input logic sign, input exp_t ex,
                                          input sig_t sg, input shamt_t shr, input shamt_t shl,
                                          input logic [4:0] spec);
    logic [63:0] s;
    logic [5:0]  n;
    logic [24:0] m;
    logic        rb, sb, lost, up;
    logic [25:0] sum;
    logic [23:0] mr;
    exp_t        e;
    word_t       r;
    flags_t      f;
    logic        inv, inf, snan, qnan, nsign;
    {inv, inf, snan, qnan, nsign} = spec;
    f = '0;
    if (shr != 5'd0 || sg[27]) begin
      n  = (shr != 5'd0) ? {1'b0, shr} : 6'd1;    // carry alone means shift by one
      s  = {36'd0, sg};
      rb = s[n + 6'd2];                           // bit landing on position 2
      sb = |(s & ((64'd1 << (n + 6'd2)) - 64'd1));
      m  = 25'(s >> (n + 6'd3));
      e  = ex + {4'd0, n};
    end else begin
      s  = {36'd0, sg << shl};
      m  = s[27:3];
      rb = s[2];
      sb = |s[1:0];
      e  = ex - {5'd0, shl};
    end
    lost = rb | sb;
    case (rm)
      RM_NEAREST: up = rb & (sb | m[0]);   // ties to even
      RM_TO_ZERO: up = 1'b0;
      RM_TO_INFP: up = lost & ~sign;
      default:    up = lost & sign;
    endcase
    sum = {1'b0, m} + {25'd0, up};
    if (sum[24]) begin
      mr = sum[24:1];   // renormalize after carry-out
      e  = e + 10'd1;
    end else begin
      mr = sum[23:0];
    end
    if (qnan | snan) begin
      r = {nsign, QNAN_BODY};
      f[FL_QNF] = qnan;
      f[FL_IVF] = snan;
      f[FL_SNF] = snan;
    end else if (inv) begin
      r = {sign, SNAN_BODY};
      f[FL_IVF] = 1'b1;
      f[FL_SNF] = 1'b1;
    end else if (inf || e > EXP_MAX) begin
      r = {sign, INF_BODY};
      f[FL_INF] = 1'b1;
      f[FL_OVF] = !inf;
      f[FL_IXF] = lost || !inf;
    end else if (!mr[23]) begin
      r = {sign, 8'd0, mr[22:0]};               // denormal or zero
      f[FL_UNF] = lost;
      f[FL_ZF]  = (mr == 24'd0);
      f[FL_IXF] = lost;
    end else begin
      r = {sign, e[7:0], mr[22:0]};
      f[FL_IXF] = lost;
    end
    return {f, r};
  endfunction

  task automatic check_val(input string name, input logic [63:0] expv, input logic [63:0] actv);
    checks++;
    if (actv !== expv) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expv, actv);
    end
  endtask

  ////////////////////////////////////////
  // in-order compare
  ////////////////////////////////////////

  always @(posedge clk) last_adv <= adv_i;

  always @(negedge clk) begin
    if (!rst) begin
      if (!last_adv && (valid_o !== prev_valid || result_o !== prev_result ||
                        flags_o !== prev_flags)) begin
        errors++;
        $display("outputs changed on a clock edge without an advance");
      end else if (last_adv && valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("valid_o high with no operation pending");
        end else begin
          check_val(test_name, {24'd0, exp_q.pop_front()}, {24'd0, flags_o, result_o});
        end
      end
    end
    prev_valid  = valid_o;
    prev_result = result_o;
    prev_flags  = flags_o;
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic drive_idle();
    valid_i = 1'b0;
    sign_i  = 1'b0;
    exp_i   = '0;
    sig_i   = '0;
    shr_i   = '0;
    shl_i   = '0;
    {inv_i, inf_i, snan_i, qnan_i, nan_sign_i} = 5'b0;
    adv_i   = 1'b1;
  endtask

  // drives one op and waits for the edge that samples it
  task automatic issue_op(input logic sign, input exp_t ex, input sig_t sg, input shamt_t shr,
                          input shamt_t shl, input logic [4:0] spec, input logic stall);
    int          waited;
    logic        done;
    logic [39:0] expv;
    #1;
    valid_i = 1'b1;
    sign_i  = sign;
    exp_i   = ex;
    sig_i   = sg;
    shr_i   = shr;
    shl_i   = shl;
    {inv_i, inf_i, snan_i, qnan_i, nan_sign_i} = spec;
    adv_i   = stall ? (($random(seed) % 2) != 0) : 1'b1;
    expv    = fpr_ref(rmode_i, sign, ex, sg, shr, shl, spec);
    waited  = 0;
    done    = 1'b0;
    while (!done && waited < 64) begin
      @(posedge clk);
      if (adv_i) begin
        done = 1'b1;
      end else begin
        #1 adv_i = stall ? (($random(seed) % 2) != 0) : 1'b1;   // inputs held
        waited++;
      end
    end
    if (done) exp_q.push_back(expv);
    else begin
      errors++;
      $display("operation was never sampled by an advance");
    end
  endtask

  // kind 0 normal, 1 carry set, 2 right shift, 3 left shift
  task automatic random_op(input logic [1:0] kind, input logic stall);
    logic [31:0] r1, r2;
    sig_t        sg;
    exp_t        ex;
    shamt_t      sr, sl;
    logic [2:0]  k;
    r1 = $random(seed);
    r2 = $random(seed);
    sr = '0;
    sl = '0;
    k  = r2[10:8];
    case (kind)
      2'd0: begin
        sg = {2'b01, r1[25:0]};
        ex = 10'd1 + 10'(r2[7:0] % 200);
      end
      2'd1: begin
        sg = {1'b1, r1[26:0]};
        ex = 10'd1 + 10'(r2[7:0] % 200);
      end
      2'd2: begin
        sg = {2'b01, r1[25:0]};
        sr = shamt_t'(1 + r2[15:8] % 31);   // lands below the hidden bit
        ex = {4'd0, r2[5:0]};
      end
      default: begin
        sg = sig_t'({2'b00, r1[25:0]} >> k);
        sl = {2'b00, k} + {4'd0, r2[12]};  // never past bit 26
        ex = 10'd20 + 10'(r2[7:0] % 100);
      end
    endcase
    issue_op(r2[31], ex, sg, sr, sl, 5'b0, stall);
  endtask

  task automatic drain();
    int waited;
    #1 drive_idle();
    waited = 0;
    while (exp_q.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("results still missing after the pipeline drained");
      exp_q.delete();
    end
    @(posedge clk);
  endtask

  // mode only changes with the pipe empty
  task automatic set_group(input string name, input rmode_t mode);
    #1;
    test_name = name;
    rmode_i   = mode;
    @(posedge clk);
  endtask

  task automatic run_random(input string name, input rmode_t mode, input int count,
                            input logic stall);
    logic [31:0] r;
    set_group(name, mode);
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      random_op(r[1:0], stall);
    end
    drain();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    seed    = 4;
    errors  = 0;
    checks  = 0;
    clk     = 1'b0;
    rst     = 1'b1;
    flush_i = 1'b0;
    rmode_i = RM_NEAREST;
    test_name = "reset";
    drive_idle();
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
    check_val("reset", 64'd0, {23'd0, valid_o, flags_o, result_o});
    @(posedge clk);

    run_random("rnd_nearest", RM_NEAREST, 60, 1'b0);
    run_random("rnd_to_zero", RM_TO_ZERO, 60, 1'b0);
    run_random("rnd_to_infp", RM_TO_INFP, 60, 1'b0);
    run_random("rnd_to_infm", RM_TO_INFM, 60, 1'b0);

    // all-ones fraction rolls the carry into the exponent
    for (int md = 0; md < 4; md++) begin
      set_group("carry_out", rmode_t'(md));
      issue_op(1'b0, 10'd127, 28'h7ff_fffc, 5'd0, 5'd0, 5'b0, 1'b0);
      issue_op(1'b1, 10'd127, 28'h7ff_fffd, 5'd0, 5'd0, 5'b0, 1'b0);
      issue_op(1'b0, 10'd254, 28'h7ff_fffe, 5'd0, 5'd0, 5'b0, 1'b0);  // may overflow
      drain();
    end

    set_group("ovf_unf", RM_NEAREST);
    issue_op(1'b0, 10'd300, 28'h400_0000, 5'd0, 5'd0, 5'b0, 1'b0);
    issue_op(1'b1, 10'd255, 28'h400_0000, 5'd0, 5'd0, 5'b0, 1'b0);
    issue_op(1'b0, 10'd254, 28'h400_0000, 5'd0, 5'd0, 5'b0, 1'b0);  // largest normal
    issue_op(1'b0, 10'd0,   28'h000_0000, 5'd0, 5'd0, 5'b0, 1'b0);  // exact zero
    issue_op(1'b1, 10'd0,   28'h000_0003, 5'd0, 5'd0, 5'b0, 1'b0);  // sticky only
    issue_op(1'b0, 10'd0,   28'h123_4567, 5'd0, 5'd0, 5'b0, 1'b0);
    issue_op(1'b0, 10'd1,   28'h400_0001, 5'd3, 5'd0, 5'b0, 1'b0);
    drain();

    // spec order {inv, inf, snan, qnan, nan_sign}
    set_group("specials", RM_NEAREST);
    issue_op(1'b0, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b00011, 1'b0);
    issue_op(1'b1, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b00100, 1'b0);
    issue_op(1'b0, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b00111, 1'b0);
    issue_op(1'b1, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b10000, 1'b0);
    issue_op(1'b1, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b01000, 1'b0);
    issue_op(1'b0, 10'd127, 28'h400_0001, 5'd0, 5'd0, 5'b01000, 1'b0);  // inf with lost bits
    issue_op(1'b0, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b11000, 1'b0);
    issue_op(1'b0, 10'd127, 28'h400_0000, 5'd0, 5'd0, 5'b10010, 1'b0);
    drain();

    run_random("stall", RM_NEAREST, 80, 1'b1);

    // flush drops both ops in flight
    set_group("flush", RM_NEAREST);
    #1;
    valid_i = 1'b1;
    exp_i   = 10'd100;
    sig_i   = 28'h4a0_0000;
    @(posedge clk);
    #1 exp_i = 10'd101;
    flush_i  = 1'b1;
    @(posedge clk);
    #1 flush_i = 1'b0;
    drive_idle();
    repeat (3) begin
      @(posedge clk);
      #1 check_val("flush", 64'd0, {63'd0, valid_o});
    end
    @(posedge clk);
    issue_op(1'b0, 10'd90, 28'h455_5555, 5'd0, 5'd0, 5'b0, 1'b0);
    drain();

    sva_fails = uut.u_sva.fail_count;
    $display("checks %0d  errors %0d  assertion failures %0d", checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verification/fpr_sva.sv
/*
 * output-stage assertions for the rounding pipeline, bound into fpr_top
 */
`timescale 1ns/1ns

module fpr_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 flush_i,
  input logic                 valid_o,
  input fpr_fmt_pkg::word_t   result_o,
  input fpr_ctrl_pkg::flags_t flags_o
);
  import fpr_ctrl_pkg::*;

  int fail_count = 0;   // read by the testbench at the end

  // reset empties the output stage
  a_reset_empty: assert property (@(posedge clk) $past(rst) |-> !valid_o)
    else begin
      $error("valid_o high right after reset");
      fail_count++;
    end

  // flush clears valid, result and flags together
  a_flush_zero: assert property (@(posedge clk)
      $past(flush_i) |-> (!valid_o && result_o == '0 && flags_o == '0))
    else begin
      $error("outputs not cleared after flush");
      fail_count++;
    end

  a_inf_ovf_valid: assert property (@(posedge clk) disable iff (rst)
      (flags_o[FL_INF] || flags_o[FL_OVF]) |-> valid_o)
    else begin
      $error("inf or ovf flag raised without valid_o");
      fail_count++;
    end

endmodule

bind fpr_top fpr_sva u_sva (
  .clk (clk), .rst (rst), .flush_i (flush_i), .valid_o (valid_o),
  .result_o (result_o), .flags_o (flags_o)
);

//--- design/fpr_top.sv
/*
 * two-stage fpu rounding pipeline: align, round, pack
 * one arithmetic source in, packed single plus flags out
 */
`timescale 1ns/1ns

module fpr_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,       // global stall-enable
  input  logic                 flush_i,
  input  fpr_ctrl_pkg::rmode_t rmode_i,     // not pipelined
  input  logic                 valid_i,
  input  logic                 sign_i,
  input  fpr_fmt_pkg::exp_t    exp_i,
  input  fpr_fmt_pkg::sig_t    sig_i,
  input  fpr_fmt_pkg::shamt_t  shr_i,
  input  fpr_fmt_pkg::shamt_t  shl_i,
  input  logic                 inv_i,
  input  logic                 inf_i,
  input  logic                 snan_i,
  input  logic                 qnan_i,
  input  logic                 nan_sign_i,
  output fpr_fmt_pkg::word_t   result_o,
  output fpr_ctrl_pkg::flags_t flags_o,
  output logic                 valid_o
);
  import fpr_fmt_pkg::*;

  // stage-1 bus
  logic  s1_valid, s1_sign, s1_round, s1_sticky;
  logic  s1_inv, s1_inf, s1_snan, s1_qnan, s1_nan_sign;
  exp_t  s1_exp;
  mant_t s1_mant;
  // rounder out
  exp_t        rnd_exp;
  logic [23:0] rnd_mant;
  logic        lost;

  fpr_align u_align (
    .clk (clk), .rst (rst), .adv_i (adv_i), .flush_i (flush_i),
    .valid_i (valid_i), .sign_i (sign_i), .exp_i (exp_i), .sig_i (sig_i),
    .shr_i (shr_i), .shl_i (shl_i), .inv_i (inv_i), .inf_i (inf_i),
    .snan_i (snan_i), .qnan_i (qnan_i), .nan_sign_i (nan_sign_i),
    .s1_valid_o (s1_valid), .s1_sign_o (s1_sign), .s1_exp_o (s1_exp),
    .s1_mant_o (s1_mant), .s1_round_o (s1_round), .s1_sticky_o (s1_sticky),
    .s1_inv_o (s1_inv), .s1_inf_o (s1_inf), .s1_snan_o (s1_snan),
    .s1_qnan_o (s1_qnan), .s1_nan_sign_o (s1_nan_sign)
  );

  fpr_round u_round (
    .rmode_i (rmode_i), .s1_sign_i (s1_sign), .s1_exp_i (s1_exp),
    .s1_mant_i (s1_mant), .s1_round_i (s1_round), .s1_sticky_i (s1_sticky),
    .rnd_exp_o (rnd_exp), .rnd_mant_o (rnd_mant), .lost_o (lost)
  );

  fpr_pack u_pack (
    .clk (clk), .rst (rst), .adv_i (adv_i), .flush_i (flush_i),
    .s1_valid_i (s1_valid), .s1_sign_i (s1_sign), .s1_inv_i (s1_inv),
    .s1_inf_i (s1_inf), .s1_snan_i (s1_snan), .s1_qnan_i (s1_qnan),
    .s1_nan_sign_i (s1_nan_sign), .rnd_exp_i (rnd_exp),
    .rnd_mant_i (rnd_mant), .lost_i (lost),
    .result_o (result_o), .flags_o (flags_o), .valid_o (valid_o)
  );

endmodule

//--- design/fpr_pack.sv
/*
 * result step: chooses special or rounded result, packs the ieee single,
 * builds exception flags and registers all outputs on advance
 */
`timescale 1ns/1ns

module fpr_pack (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,
  input  logic                 flush_i,
  input  logic                 s1_valid_i,
  input  logic                 s1_sign_i,
  input  logic                 s1_inv_i,
  input  logic                 s1_inf_i,
  input  logic                 s1_snan_i,
  input  logic                 s1_qnan_i,
  input  logic                 s1_nan_sign_i,
  input  fpr_fmt_pkg::exp_t    rnd_exp_i,
  input  logic [23:0]          rnd_mant_i,
  input  logic                 lost_i,
  output fpr_fmt_pkg::word_t   result_o,
  output fpr_ctrl_pkg::flags_t flags_o,
  output logic                 valid_o
);
  import fpr_fmt_pkg::*;
  import fpr_ctrl_pkg::*;

  word_t  t_res;
  flags_t t_fl;
  logic   exp_ovf;
  logic   denorm;

  assign exp_ovf = (rnd_exp_i > EXP_MAX);   // negative exp wraps here too
  assign denorm  = ~rnd_mant_i[23];         // hidden bit lost

  ////////////////////////////////////////
  // result select, priority order
  ////////////////////////////////////////

  always_comb begin
    t_fl = '0;
    if (s1_qnan_i | s1_snan_i) begin
      // any nan in gives quiet nan out
      t_res          = {s1_nan_sign_i, QNAN_BODY};
      t_fl[FL_QNF]   = s1_qnan_i;
      t_fl[FL_IVF]   = s1_snan_i;
      t_fl[FL_SNF]   = s1_snan_i;
    end else if (s1_inv_i) begin
      t_res          = {s1_sign_i, SNAN_BODY};
      t_fl[FL_IVF]   = 1'b1;
      t_fl[FL_SNF]   = 1'b1;
    end else if (exp_ovf | s1_inf_i) begin
      t_res          = {s1_sign_i, INF_BODY};
      t_fl[FL_INF]   = 1'b1;
      t_fl[FL_OVF]   = ~s1_inf_i;              // only a computed overflow
      t_fl[FL_IXF]   = lost_i | ~s1_inf_i;
    end else if (denorm) begin
      t_res          = {s1_sign_i, 8'd0, rnd_mant_i[22:0]};
      t_fl[FL_UNF]   = lost_i;
      t_fl[FL_ZF]    = ~(|rnd_mant_i);
      t_fl[FL_IXF]   = lost_i;
    end else begin
      t_res          = {s1_sign_i, rnd_exp_i[7:0], rnd_mant_i[22:0]};
      t_fl[FL_IXF]   = lost_i;
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result_o <= '0;
      flags_o  <= '0;
      valid_o  <= 1'b0;
    end else if (flush_i) begin
      result_o <= '0;     // flush also zeroes payload
      flags_o  <= '0;
      valid_o  <= 1'b0;
    end else if (adv_i) begin
      result_o <= t_res;
      flags_o  <= t_fl;
      valid_o  <= s1_valid_i;
    end
  end

endmodule

//--- design/fpr_round.sv
/*
 * stage 2 rounding decision: picks round-up per mode, adds the increment and
 * renormalizes on mantissa carry-out. purely combinational on stage 1
 */
`timescale 1ns/1ns

module fpr_round (
  input  fpr_ctrl_pkg::rmode_t rmode_i,
  input  logic                 s1_sign_i,
  input  fpr_fmt_pkg::exp_t    s1_exp_i,
  input  fpr_fmt_pkg::mant_t   s1_mant_i,
  input  logic                 s1_round_i,
  input  logic                 s1_sticky_i,
  output fpr_fmt_pkg::exp_t    rnd_exp_o,
  output logic [23:0]          rnd_mant_o,  // hidden bit at 23
  output logic                 lost_o       // inexact before rounding
);
  import fpr_fmt_pkg::*;
  import fpr_ctrl_pkg::*;

  logic  rm_nearest, rm_to_infp, rm_to_infm;
  logic  rnd_up;
  mant_t mant_sum;
  logic  carry;

  // mode decode, to-zero never rounds up
  assign rm_nearest = (rmode_i == RM_NEAREST);
  assign rm_to_infp = (rmode_i == RM_TO_INFP);
  assign rm_to_infm = (rmode_i == RM_TO_INFM);

  assign lost_o = s1_round_i | s1_sticky_i;

  // nearest: above half, or exact half with odd lsb
  assign rnd_up = (rm_nearest & s1_round_i & (s1_sticky_i | s1_mant_i[0])) |
                  (rm_to_infp & ~s1_sign_i & lost_o) |
                  (rm_to_infm &  s1_sign_i & lost_o);

  assign mant_sum = s1_mant_i + {24'd0, rnd_up};
  assign carry    = mant_sum[24];  // 1.111.. rolled over to 10.000..

  ////////////////////////////////////////
  // renormalize
  ////////////////////////////////////////

  assign rnd_mant_o = carry ? mant_sum[24:1] : mant_sum[23:0];
  assign rnd_exp_o  = s1_exp_i + {9'd0, carry};

endmodule

//--- design/fpr_align.sv
/*
 * stage 1 of the rounding pipe: aligns the incoming significand by a right
 * or left shift, gathers round and sticky bits, registers on advance
 */
`timescale 1ns/1ns

module fpr_align (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 adv_i,       // pipe advance
  input  logic                 flush_i,     // drop stage-1 op
  input  logic                 valid_i,
  input  logic                 sign_i,
  input  fpr_fmt_pkg::exp_t    exp_i,
  input  fpr_fmt_pkg::sig_t    sig_i,
  input  fpr_fmt_pkg::shamt_t  shr_i,       // requested right shift
  input  fpr_fmt_pkg::shamt_t  shl_i,       // requested left shift
  input  logic                 inv_i,
  input  logic                 inf_i,
  input  logic                 snan_i,
  input  logic                 qnan_i,
  input  logic                 nan_sign_i,
  output logic                 s1_valid_o,
  output logic                 s1_sign_o,
  output fpr_fmt_pkg::exp_t    s1_exp_o,
  output fpr_fmt_pkg::mant_t   s1_mant_o,
  output logic                 s1_round_o,
  output logic                 s1_sticky_o,
  output logic                 s1_inv_o,
  output logic                 s1_inf_o,
  output logic                 s1_snan_o,
  output logic                 s1_qnan_o,
  output logic                 s1_nan_sign_o
);
  import fpr_fmt_pkg::*;

  shamt_t      shr_eff;   // right shift actually applied
  logic        right_en;
  logic [59:0] wide_r;    // sig with 32 guard bits below
  sig_t        sig_l;     // left-shifted sig
  mant_t       t_mant;
  logic        t_round;
  logic        t_sticky;
  exp_t        t_exp;

  // explicit right shift wins, else a set carry forces shift by one
  assign shr_eff  = (|shr_i) ? shr_i : {4'd0, sig_i[27]};
  assign right_en = |shr_eff;

  assign wide_r = {sig_i, 32'd0} >> shr_eff;
  assign sig_l  = sig_i << shl_i;  // zeros fill the low end

  ////////////////////////////////////////
  // field select
  ////////////////////////////////////////

  always_comb begin
    if (right_en) begin
      t_mant   = wide_r[59:35];
      t_round  = wide_r[34];       // lands on sig bit 2
      t_sticky = |wide_r[33:0];    // incl. everything shifted out
      t_exp    = exp_i + {5'd0, shr_eff};
    end else begin
      t_mant   = sig_l[27:3];
      t_round  = sig_l[2];
      t_sticky = |sig_l[1:0];
      t_exp    = exp_i - {5'd0, shl_i};
    end
  end

  // stage-1 payload, holds while stalled
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign_o     <= sign_i;
      s1_exp_o      <= t_exp;
      s1_mant_o     <= t_mant;
      s1_round_o    <= t_round;
      s1_sticky_o   <= t_sticky;
      s1_inv_o      <= inv_i;
      s1_inf_o      <= inf_i;
      s1_snan_o     <= snan_i;
      s1_qnan_o     <= qnan_i;
      s1_nan_sign_o <= nan_sign_i;
    end
  end

  // stage-1 valid
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid_o <= 1'b0;
    end else if (adv_i) begin
      s1_valid_o <= valid_i;
    end
  end

endmodule

//--- design/fpr_ctrl_pkg.sv
/*
 * rounding-mode codes and the exception flag vector of the rounding stage
 */
package fpr_ctrl_pkg;

  // rounding mode, sampled unpipelined by stage 2
  typedef logic [1:0] rmode_t;

  localparam rmode_t RM_NEAREST = 2'd0;  // nearest, ties to even
  localparam rmode_t RM_TO_ZERO = 2'd1;  // truncate
  localparam rmode_t RM_TO_INFP = 2'd2;  // toward +inf
  localparam rmode_t RM_TO_INFM = 2'd3;  // toward -inf

  ////////////////////////////////////////
  // exception flags
  ////////////////////////////////////////

  typedef logic [7:0] flags_t;

  localparam int FL_OVF = 0;  // overflow
  localparam int FL_UNF = 1;  // underflow
  localparam int FL_SNF = 2;  // signaling nan
  localparam int FL_QNF = 3;  // quiet nan
  localparam int FL_ZF  = 4;  // zero result
  localparam int FL_IXF = 5;  // inexact
  localparam int FL_IVF = 6;  // invalid
  localparam int FL_INF = 7;  // infinity

endpackage

//--- design/fpr_fmt_pkg.sv
/*
 * single-precision format definitions shared by the rounding pipeline
 * widths, vector types and the special-value bodies below the sign bit
 */
package fpr_fmt_pkg;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  typedef logic [31:0] word_t;   // packed ieee single / result word
  typedef logic [9:0]  exp_t;    // biased exponent, extra headroom bits
  typedef logic [27:0] sig_t;    // {carry, hidden, frac[22:0], round, sticky[1:0]}
  typedef logic [24:0] mant_t;   // {carry, hidden, frac[22:0]} after align
  typedef logic [4:0]  shamt_t;  // shift amount

  ////////////////////////////////////////
  // constants
  ////////////////////////////////////////

  // largest finite biased exponent
  localparam exp_t EXP_MAX = 10'd254;

  // bodies below the sign, exponent all ones
  localparam logic [30:0] INF_BODY  = 31'h7f80_0000;  // zero fraction
  localparam logic [30:0] QNAN_BODY = 31'h7fc0_0000;  // quiet bit only
  localparam logic [30:0] SNAN_BODY = 31'h7fbf_ffff;  // quiet bit clear, rest set

endpackage
